// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 8;
    localparam int OFFS_W = 5;
    localparam int TGT_W = OFFS_W + 1;      // Jump target, bits 5..0.
    localparam int PAGE_W = ADDR_W - OFFS_W; // Upper bits of a data address.

    typedef enum logic [1:0] {
        op_jmp = 2'b00,
        op_ld  = 2'b01,
        op_st  = 2'b10,
        op_add = 2'b11
    } opcode_e;

    // One instruction byte, msb first.
    typedef struct packed {
        opcode_e           op;
        logic              sel_a;   // 1 selects a, 0 selects b.
        logic [OFFS_W-1:0] offset;
    } inst_t;

endpackage

// ==== design/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    // Encoded as {en, done} seen from the core.
    typedef enum logic [1:0] {
        st_idle     = 2'b00,
        st_busy     = 2'b10,
        st_complete = 2'b11
    } stage_state_e;

    typedef enum logic [1:0] {
        own_none  = 2'b00,
        own_fetch = 2'b01,
        own_exec  = 2'b10
    } bus_owner_e;

endpackage

// ==== design/fetch_unit.sv ====
module fetch_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  logic [cpu_isa_pkg::ADDR_W-1:0] pc,
    input  logic [cpu_isa_pkg::DATA_W-1:0] data_in,
    input  logic                           mem_ready,
    output logic                           req,
    output logic [cpu_isa_pkg::ADDR_W-1:0] addr,
    output logic [cpu_isa_pkg::DATA_W-1:0] inst,
    output logic                           done
);

    import cpu_ctrl_pkg::*;

    stage_state_e state;
    logic         stale;    // Enable dropped while the read was on the bus.

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            stale <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (en) state <= st_busy;
                end
                st_busy: begin
                    if (!en) stale <= 1'b1;
                    if (mem_ready) begin
                        // A flushed read still finishes, but its byte is dropped.
                        state <= (en && !stale) ? st_complete : st_idle;
                        stale <= 1'b0;
                    end
                end
                st_complete: begin
                    if (!en) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && en) addr <= pc;
        if (state == st_busy && mem_ready) inst <= data_in;
    end

    assign req  = (state == st_busy);
    assign done = (state == st_complete);

    // Request address holds until the bus answers.
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        req && !mem_ready |=> $stable(addr));

endmodule

// ==== design/decode_unit.sv ====
module decode_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  logic [cpu_isa_pkg::DATA_W-1:0] inst,
    output cpu_isa_pkg::opcode_e           op,
    output logic                           sel_a,
    output logic [cpu_isa_pkg::OFFS_W-1:0] offset,
    output logic [cpu_isa_pkg::TGT_W-1:0]  target,
    output logic                           done
);

    import cpu_isa_pkg::*;

    inst_t fields;

    assign fields = inst_t'(inst);  // Opcode bits land in the enum here.

    always_ff @(posedge clk) begin
        if (!rst) begin
            done <= 1'b0;
        end else begin
            done <= en;
        end
    end

    // Fields are taken in the first enabled cycle.
    always_ff @(posedge clk) begin
        if (en && !done) begin
            op     <= fields.op;
            sel_a  <= fields.sel_a;
            offset <= fields.offset;
            target <= {fields.sel_a, fields.offset};
        end
    end

endmodule

// ==== design/exec_unit.sv ====
module exec_unit #(
    parameter logic [cpu_isa_pkg::PAGE_W-1:0] DATA_PAGE
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  cpu_isa_pkg::opcode_e           op,
    input  logic [cpu_isa_pkg::OFFS_W-1:0] offset,
    input  logic [cpu_isa_pkg::DATA_W-1:0] operand,
    input  logic [cpu_isa_pkg::DATA_W-1:0] data_in,
    input  logic                           mem_ready,
    output logic                           req,
    output logic [cpu_isa_pkg::ADDR_W-1:0] addr,
    output logic [cpu_isa_pkg::DATA_W-1:0] wdata,
    output logic                           we,
    output logic [cpu_isa_pkg::DATA_W-1:0] result,
    output logic                           done
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    stage_state_e state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            we    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (en) begin
                        state <= st_busy;
                        we    <= (op == op_st);
                    end
                end
                st_busy: begin
                    if (mem_ready) begin
                        state <= st_complete;
                        we    <= 1'b0;
                    end
                end
                st_complete: begin
                    if (!en) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && en) begin
            addr  <= {DATA_PAGE, offset};   // Data window.
            wdata <= operand;
        end
        if (state == st_busy && mem_ready) begin
            case (op)
                op_ld:   result <= data_in;
                op_add:  result <= operand + data_in;  // Wraps at 256.
                default: result <= operand;
            endcase
        end
    end

    assign req  = (state == st_busy);
    assign done = (state == st_complete);

    a_we_in_req: assert property (@(posedge clk) disable iff (!rst) we |-> req);

    // The core resolves jumps before hand-off.
    a_no_jmp: assert property (@(posedge clk) disable iff (!rst) en |-> op != op_jmp);

endmodule

// ==== design/reg_file.sv ====
module reg_file (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wb_en,
    input  logic                           sel_a,
    input  logic [cpu_isa_pkg::DATA_W-1:0] wb_value,
    input  logic                           rd_sel_a,
    output logic [cpu_isa_pkg::DATA_W-1:0] operand,
    output logic                           done
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    stage_state_e     state;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= st_idle;
            a     <= '0;
            b     <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (wb_en) begin
                        state <= st_complete;
                        if (sel_a) a <= wb_value;
                        else b <= wb_value;
                    end
                end
                st_complete: begin
                    if (!wb_en) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign operand = rd_sel_a ? a : b;
    assign done    = (state == st_complete);

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           fetch_req,
    input  logic [cpu_isa_pkg::ADDR_W-1:0] fetch_addr,
    input  logic                           exec_req,
    input  logic [cpu_isa_pkg::ADDR_W-1:0] exec_addr,
    input  logic [cpu_isa_pkg::DATA_W-1:0] exec_wdata,
    input  logic                           exec_we,
    output logic                           fetch_ready,
    output logic                           exec_ready,
    input  logic                           mem_ready,
    output logic                           mem_req,
    output logic [cpu_isa_pkg::ADDR_W-1:0] addr,
    output logic [cpu_isa_pkg::DATA_W-1:0] data_out,
    output logic                           we
);

    import cpu_ctrl_pkg::*;

    bus_owner_e owner;

    always_ff @(posedge clk) begin
        if (!rst) begin
            owner   <= own_none;
            mem_req <= 1'b0;
            we      <= 1'b0;
        end else if (owner == own_none) begin
            if (exec_req) begin     // Execute goes first.
                owner   <= own_exec;
                mem_req <= 1'b1;
                we      <= exec_we;
            end else if (fetch_req) begin
                owner   <= own_fetch;
                mem_req <= 1'b1;
                we      <= 1'b0;
            end
        end else if (mem_ready) begin
            owner   <= own_none;
            mem_req <= 1'b0;
            we      <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (owner == own_none) begin
            if (exec_req) begin
                addr     <= exec_addr;
                data_out <= exec_wdata;
            end else if (fetch_req) begin
                addr <= fetch_addr;
            end
        end
    end

    assign fetch_ready = mem_ready && (owner == own_fetch);
    assign exec_ready  = mem_ready && (owner == own_exec);

    a_req_owned: assert property (@(posedge clk) disable iff (!rst)
        mem_req |-> owner != own_none);

endmodule

// ==== design/cpu_core.sv ====
module cpu_core #(
    parameter logic [cpu_isa_pkg::PAGE_W-1:0] DATA_PAGE = 7
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpu_isa_pkg::DATA_W-1:0] data_in,
    input  logic                           mem_ready,
    output logic [cpu_isa_pkg::ADDR_W-1:0] addr,
    output logic [cpu_isa_pkg::DATA_W-1:0] data_out,
    output logic                           we,
    output logic                           mem_req
);

    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [ADDR_W-1:0] pc;
    logic              fetch_en, decode_en, exec_en, wb_en;
    logic              fetch_done, decode_done, exec_done, wb_done;
    stage_state_e      fetch_st, decode_st, exec_st, wb_st;
    logic              take_fetch, take_decode, take_exec;

    logic              fetch_req;
    logic [ADDR_W-1:0] fetch_addr;
    logic              fetch_ready;
    logic [DATA_W-1:0] fetch_inst;

    logic [DATA_W-1:0] dec_inst;
    opcode_e           dec_op;
    logic              dec_sel_a;
    logic [OFFS_W-1:0] dec_offset;
    logic [TGT_W-1:0]  dec_target;

    opcode_e           exec_op;
    logic [OFFS_W-1:0] exec_offset;
    logic              exec_sel_a;
    logic [DATA_W-1:0] operand;
    logic              exec_req;
    logic [ADDR_W-1:0] exec_addr;
    logic [DATA_W-1:0] exec_wdata;
    logic              exec_we;
    logic              exec_ready;
    logic [DATA_W-1:0] exec_result;
    logic              wb_sel_a;

    assign fetch_st  = stage_state_e'({fetch_en, fetch_done});
    assign decode_st = stage_state_e'({decode_en, decode_done});
    assign exec_st   = stage_state_e'({exec_en, exec_done});
    assign wb_st     = stage_state_e'({wb_en, wb_done});

    assign take_fetch  = (fetch_st == st_complete) && (decode_st == st_idle);
    // Operands are read only once the previous writeback is over.
    assign take_decode = (decode_st == st_complete) && (exec_st == st_idle)
                         && (wb_st == st_idle);
    assign take_exec   = (exec_st == st_complete) && (wb_st == st_idle);

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc        <= '0;
            fetch_en  <= 1'b0;
            decode_en <= 1'b0;
            exec_en   <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            if (take_fetch) begin
                decode_en <= 1'b1;
                fetch_en  <= 1'b0;
                pc        <= pc + 1'b1;
            end else if (fetch_st == st_idle) begin
                fetch_en <= 1'b1;
            end

            if (take_decode) begin
                decode_en <= 1'b0;
                if (dec_op == op_jmp) begin
                    pc       <= ADDR_W'(dec_target);
                    fetch_en <= 1'b0;   // Throw away the prefetched byte.
                end else begin
                    exec_en <= 1'b1;
                end
            end

            if (take_exec) begin
                exec_en <= 1'b0;
                wb_en   <= (exec_op != op_st);  // Stores have nothing to write back.
            end else if (wb_st == st_complete) begin
                wb_en <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_fetch) dec_inst <= fetch_inst;
        if (take_decode && dec_op != op_jmp) begin
            exec_op     <= dec_op;
            exec_offset <= dec_offset;
            exec_sel_a  <= dec_sel_a;
        end
        if (take_exec) wb_sel_a <= exec_sel_a;
    end

    fetch_unit i_fetch (
        .clk       (clk),
        .rst       (rst),
        .en        (fetch_en),
        .pc        (pc),
        .data_in   (data_in),
        .mem_ready (fetch_ready),
        .req       (fetch_req),
        .addr      (fetch_addr),
        .inst      (fetch_inst),
        .done      (fetch_done)
    );

    decode_unit i_decode (
        .clk    (clk),
        .rst    (rst),
        .en     (decode_en),
        .inst   (dec_inst),
        .op     (dec_op),
        .sel_a  (dec_sel_a),
        .offset (dec_offset),
        .target (dec_target),
        .done   (decode_done)
    );

    exec_unit #(
        .DATA_PAGE (DATA_PAGE)
    ) i_exec (
        .clk       (clk),
        .rst       (rst),
        .en        (exec_en),
        .op        (exec_op),
        .offset    (exec_offset),
        .operand   (operand),
        .data_in   (data_in),
        .mem_ready (exec_ready),
        .req       (exec_req),
        .addr      (exec_addr),
        .wdata     (exec_wdata),
        .we        (exec_we),
        .result    (exec_result),
        .done      (exec_done)
    );

    reg_file i_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_en    (wb_en),
        .sel_a    (wb_sel_a),
        .wb_value (exec_result),
        .rd_sel_a (exec_sel_a),
        .operand  (operand),
        .done     (wb_done)
    );

    mem_arbiter i_arb (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .exec_req    (exec_req),
        .exec_addr   (exec_addr),
        .exec_wdata  (exec_wdata),
        .exec_we     (exec_we),
        .fetch_ready (fetch_ready),
        .exec_ready  (exec_ready),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .addr        (addr),
        .data_out    (data_out),
        .we          (we)
    );

    // Execute takes a free bus even when fetch asks in the same cycle.
    a_exec_first: assert property (@(posedge clk) disable iff (!rst)
        exec_req && fetch_req && i_arb.owner == own_none |=> i_arb.owner == own_exec);

endmodule

// ==== testbench/tb_mem_model.sv ====
module tb_mem_model (
    input  logic       clk,
    input  logic       rst,
    input  logic       mem_req,
    input  logic [7:0] addr,
    input  logic [7:0] data_out,
    input  logic       we,
    output logic [7:0] data_in,
    output logic       mem_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [15:0] LFSR_SEED = 16'd10501;

    logic [7:0]  mem [256];
    logic [15:0] write_log [$];    // {addr, data} of each completed write.
    logic [15:0] lfsr;
    logic        active;
    logic [1:0]  wait_cnt;

    // Fibonacci form, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    initial begin
        data_in   = 8'h00;
        mem_ready = 1'b0;
        active    = 1'b0;
        wait_cnt  = 2'd0;
        lfsr      = LFSR_SEED;
    end

    always @(posedge clk) begin
        logic [15:0] s1;
        logic [15:0] s2;
        if (!rst) begin
            mem_ready <= 1'b0;
            active    <= 1'b0;
        end else begin
            mem_ready <= 1'b0;
            if (active) begin
                if (wait_cnt == 2'd0) begin
                    mem_ready <= 1'b1;
                    active    <= 1'b0;
                    if (we) begin
                        mem[addr] <= data_out;
                        write_log.push_back({addr, data_out});
                    end else begin
                        data_in <= mem[addr];
                    end
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (mem_req && !mem_ready) begin
                // Two steps, one per delay bit.
                s1 = lfsr_step(lfsr);
                s2 = lfsr_step(s1);
                wait_cnt <= {s1[0], s2[0]};
                lfsr     <= s2;
                active   <= 1'b1;
            end
        end
    end

endmodule

// ==== testbench/tb_cpu.sv ====
module tb_cpu;

    timeunit 1ns;
    timeprecision 100ps;

    import cpu_isa_pkg::*;

    typedef logic [15:0] write_q_t [$];

    localparam logic [PAGE_W-1:0] TB_PAGE = 3'd6;
    localparam int WAIT_LIMIT   = 400;
    localparam int QUIET_CYCLES = 200;

    logic       clk;
    logic       rst;
    logic [7:0] data_in;
    logic       mem_ready;
    logic [7:0] addr;
    logic [7:0] data_out;
    logic       we;
    logic       mem_req;

    logic [7:0] image [256];
    write_q_t   expected;
    logic [7:0] stop_pc;
    logic       req_open;
    logic [7:0] held_addr;
    logic [7:0] held_data;
    logic       held_we;
    int         reset_edges;
    int         requests;
    int         stop_reads;

    cpu_core #(.DATA_PAGE(TB_PAGE)) i_dut (
        .clk       (clk),
        .rst       (rst),
        .data_in   (data_in),
        .mem_ready (mem_ready),
        .addr      (addr),
        .data_out  (data_out),
        .we        (we),
        .mem_req   (mem_req)
    );

    tb_mem_model i_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .addr      (addr),
        .data_out  (data_out),
        .we        (we),
        .data_in   (data_in),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERR at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    function automatic logic [7:0] encode(input opcode_e op, input logic [5:0] field);
        return {op, field};
    endfunction

    task automatic build_image();
        for (int i = 0; i < 256; i++) begin
            image[i] = i[7:0] ^ {i[3:0], i[7:4]} ^ 8'h5a;
        end
        image[{TB_PAGE, 5'h00}] = 8'h3c;
        image[{TB_PAGE, 5'h01}] = 8'ha5;
        image[{TB_PAGE, 5'h02}] = 8'hf0;
        image[{TB_PAGE, 5'h03}] = 8'h81;
        image[0]  = encode(op_ld,  {1'b1, 5'h00});
        image[1]  = encode(op_st,  {1'b1, 5'h10});
        image[2]  = encode(op_ld,  {1'b0, 5'h01});
        image[3]  = encode(op_st,  {1'b0, 5'h11});
        image[4]  = encode(op_add, {1'b1, 5'h02});  // Wraps past 255.
        image[5]  = encode(op_add, {1'b1, 5'h03});
        image[6]  = encode(op_st,  {1'b1, 5'h12});
        image[7]  = encode(op_add, {1'b0, 5'h01});
        image[8]  = encode(op_st,  {1'b0, 5'h13});
        image[9]  = encode(op_jmp, 6'd12);
        image[10] = encode(op_st,  {1'b1, 5'h14});  // Skipped.
        image[11] = encode(op_st,  {1'b0, 5'h15});  // Skipped.
        image[12] = encode(op_ld,  {1'b1, 5'h10});
        image[13] = encode(op_add, {1'b1, 5'h11});
        image[14] = encode(op_st,  {1'b1, 5'h16});
        image[15] = encode(op_jmp, 6'd15);
    endtask

    // Runs the instruction set on a private copy, up to the self-jump.
    function automatic write_q_t expected_writes(input logic [7:0] img [256],
                                                 input logic [PAGE_W-1:0] page,
                                                 output logic [7:0] final_pc);
        logic [7:0] m [256];
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] pc;
        logic [7:0] ins;
        logic [7:0] ea;
        logic [7:0] val;
        logic       halted;
        write_q_t   wr;
        m = img;
        a = 8'h00;
        b = 8'h00;
        pc = 8'h00;
        halted = 1'b0;
        final_pc = 8'hff;
        for (int n = 0; n < 1000 && !halted; n++) begin
            ins = m[pc];
            ea  = {page, ins[4:0]};
            val = ins[5] ? a : b;
            case (opcode_e'(ins[7:6]))
                op_jmp: begin
                    if ({2'b00, ins[5:0]} == pc) begin
                        halted = 1'b1;
                        final_pc = pc;
                    end
                    pc = {2'b00, ins[5:0]};
                end
                op_st: begin
                    m[ea] = val;
                    wr.push_back({ea, val});
                end
                default: begin
                    val = (ins[7:6] == op_ld) ? m[ea] : val + m[ea];
                    if (ins[5]) a = val;
                    else b = val;
                end
            endcase
            if (ins[7:6] != op_jmp) pc = pc + 8'd1;
        end
        return wr;
    endfunction

    // Bus watcher: quiet reset, first fetch, and stable request fields.
    always @(posedge clk) begin
        if (!rst) begin
            if (reset_edges > 0) begin
                expect_equal("mem_req in reset", mem_req, 1'b0);
                expect_equal("we in reset", we, 1'b0);
            end
            reset_edges = reset_edges + 1;
        end else begin
            if (mem_req && !req_open) begin
                if (requests == 0) begin
                    expect_equal("first request addr", addr, 8'h00);
                    expect_equal("first request we", we, 1'b0);
                end
                if (addr == stop_pc && !we) stop_reads = stop_reads + 1;
                held_addr = addr;
                held_data = data_out;
                held_we   = we;
                req_open  = 1'b1;
                requests  = requests + 1;
            end else if (mem_req) begin
                expect_equal("addr during request", addr, held_addr);
                expect_equal("data_out during request", data_out, held_data);
                expect_equal("we during request", we, held_we);
            end
            if (mem_ready) req_open = 1'b0;
        end
    end

    initial begin
        logic [15:0] got;
        int          cycles;
        rst = 1'b0;
        req_open = 1'b0;
        reset_edges = 0;
        requests = 0;
        stop_reads = 0;
        build_image();
        for (int i = 0; i < 256; i++) begin
            i_mem.mem[i] = image[i];
        end
        expected = expected_writes(image, TB_PAGE, stop_pc);
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        foreach (expected[k]) begin
            cycles = 0;
            while (i_mem.write_log.size() == 0 && cycles < WAIT_LIMIT) begin
                @(posedge clk);
                cycles++;
            end
            if (i_mem.write_log.size() == 0) begin
                $display("Timeout: store %0d never reached the memory bus", k);
                stop_on_failure();
            end
            got = i_mem.write_log.pop_front();
            expect_equal("write addr", got[15:8], expected[k][15:8]);
            expect_equal("write data", got[7:0], expected[k][7:0]);
        end

        cycles = 0;
        while (stop_reads < 2 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (stop_reads < 2) begin
            $display("Timeout: the final self-jump was never executed");
            stop_on_failure();
        end

        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(posedge clk);
        end
        if (i_mem.write_log.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            got = i_mem.write_log.pop_front();
            $display("Unexpected write of %0h to address %0h after the final jump",
                     got[7:0], got[15:8]);
            stop_on_failure();
        end
    end

endmodule

// ==== vlog.f ====
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/fetch_unit.sv
design/decode_unit.sv
design/exec_unit.sv
design/reg_file.sv
design/mem_arbiter.sv
design/cpu_core.sv
testbench/tb_mem_model.sv
testbench/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cpu_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
        -f vlog.f --top-module tb_cpu -o tb_cpu; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_cpu > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation run returned an error status"
    exit 1
fi

cat "$LOG"
if grep -q "Simulation passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
